// File: samcoupe_asic.f
hdl/asic_pkg.sv
hdl/asic_ports.sv
hdl/page_mapper.sv
hdl/mem_arbiter.sv
hdl/sys_ram.sv
hdl/midi_tx.sv
hdl/dac_audio.sv
hdl/samcoupe_asic.sv
bench/samcoupe_asic_tb.sv

// File: bench/samcoupe_asic_tb.sv
// Self-checking testbench that runs the DUT with TICK_DIV 8 and reads only RAM bytes it wrote earlier
module samcoupe_asic_tb
	import asic_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK_DIV   = 8;
	localparam int MIDI_WAIT  = TICK_DIV * (MIDI_BYTE_TICKS - MIDI_INT_TICK + 1);
	localparam int CLEAR_WAIT = TICK_DIV * (MIDI_INT_TICK + 2);

	localparam logic [2:0] OP_IOW  = 3'd0;
	localparam logic [2:0] OP_IOR  = 3'd1;
	localparam logic [2:0] OP_MW   = 3'd2;
	localparam logic [2:0] OP_MR   = 3'd3;
	localparam logic [2:0] OP_LW   = 3'd4;
	localparam logic [2:0] OP_LDRD = 3'd5;
	localparam logic [2:0] OP_MIDI = 3'd6;

	typedef struct packed {
		logic [2:0]  op;
		logic [19:0] addr;
		logic [19:0] aux;
		logic [7:0]  data;
		logic [7:0]  exp;
		logic [15:0] aud_l;
		logic [15:0] aud_r;
		logic [3:0]  border;
	} entry_t;

	logic                  clk_sys;
	logic                  reset;
	logic [CPU_ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0]     cpu_wdata;
	logic                  io_wr;
	logic                  io_rd;
	logic                  mem_wr;
	logic                  mem_rd;
	logic                  load_wr;
	logic [RAM_ADDR_W-1:0] load_addr;
	logic [DATA_W-1:0]     load_data;
	logic [DATA_W-1:0]     io_rdata;
	logic                  io_rvalid;
	logic [DATA_W-1:0]     mem_rdata;
	logic                  mem_rvalid;
	logic [3:0]            border_color;
	logic [AUDIO_W-1:0]    audio_l;
	logic [AUDIO_W-1:0]    audio_r;
	logic                  int_midi;
	logic                  midi_busy;

	// Reference state advanced while the table is built
	logic [7:0] ref_lmpr, ref_hmpr, ref_brdr, ref_latch, ref_vl, ref_vr;
	logic       ref_stb;
	logic [7:0] ref_mem [int];

	entry_t stim_q [$];
	int     seed;
	int     mismatch_cnt;
	int     failure_cnt;

	samcoupe_asic #(.TICK_DIV(TICK_DIV)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Reference model
	// ==================================================
	// Bit 20 of the result flags a refused write
	function automatic logic [20:0] map_cpu_addr(input logic [15:0] a);
		logic [4:0] pg;
		logic       rom;
		pg  = (a[15] ? ref_hmpr[4:0] : ref_lmpr[4:0]) + a[14];
		rom = (a[15:14] == 2'b00 && !ref_lmpr[5]) || (a[15:14] == 2'b11 && ref_lmpr[6]);
		if (rom)
			return {1'b1, 5'd16, a[15], a[13:0]};
		return {(a[15:14] == 2'b00) && ref_lmpr[7], 1'b0, pg, a[13:0]};
	endfunction

	// Voice doubled to 16 bits plus EAR worth 2^14 after the final shift
	function automatic logic [15:0] audio_mix(input logic [7:0] vox, input logic ear_bit);
		return 16'((vox * 1028 + ear_bit * 131072) >> 3);
	endfunction

	task automatic add_entry(input logic [2:0] op, input logic [19:0] addr,
	                         input logic [19:0] aux, input logic [7:0] data);
		entry_t      e;
		logic [20:0] m;
		e = {op, addr, aux, data, 8'h00, 36'h0};
		m = map_cpu_addr(addr[15:0]);
		case (op)
			OP_IOW: begin
				case (addr[7:0])
					PORT_LMPR: ref_lmpr = data;
					PORT_HMPR: ref_hmpr = data;
					PORT_BRDR: ref_brdr = data;
					PORT_LPTD: ref_latch = data;
					PORT_LPTS: begin
						if (!ref_stb && data[0])
							ref_vl = ref_latch;
						if (ref_stb && !data[0])
							ref_vr = ref_latch;
						ref_stb = data[0];
					end
					default: ;
				endcase
			end
			OP_IOR: begin
				case (addr[7:0])
					PORT_LMPR: e.exp = ref_lmpr;
					PORT_HMPR: e.exp = ref_hmpr;
					PORT_LPTD, PORT_LPTS: e.exp = 8'h00;
					default: e.exp = 8'hFF;
				endcase
			end
			OP_MW: begin
				if (!m[20])
					ref_mem[m[19:0]] = data;
			end
			OP_MR: e.exp = ref_mem[m[19:0]];
			OP_LW: ref_mem[addr] = data;
			OP_LDRD: begin
				e.exp = ref_mem[m[19:0]];
				ref_mem[aux] = data;
			end
			default: e.exp = 8'hEF;
		endcase
		e.aud_l  = audio_mix(ref_vl, ref_brdr[4]);
		e.aud_r  = audio_mix(ref_vr, ref_brdr[4]);
		e.border = {ref_brdr[5], ref_brdr[2:0]};
		stim_q.push_back(e);
	endtask

	// ==================================================
	// Bus driving and checks
	// ==================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic clear_strobes();
		io_wr   = 1'b0;
		io_rd   = 1'b0;
		mem_wr  = 1'b0;
		mem_rd  = 1'b0;
		load_wr = 1'b0;
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	// I/O reads answer on io_rvalid, memory reads on mem_rvalid
	function automatic logic read_valid(input logic [2:0] op);
		return (op == OP_IOR) ? io_rvalid : mem_rvalid;
	endfunction

	task automatic apply_entry(input entry_t e);
		int     cycles;
		entry_t st;
		cpu_addr  = e.addr[15:0];
		cpu_wdata = e.data;
		load_addr = e.aux;
		load_data = e.data;
		case (e.op)
			OP_IOW, OP_MIDI: io_wr = 1'b1;
			OP_IOR:  io_rd  = 1'b1;
			OP_MW:   mem_wr = 1'b1;
			OP_MR:   mem_rd = 1'b1;
			OP_LDRD: begin
				mem_rd  = 1'b1;
				load_wr = 1'b1;
			end
			default: begin
				load_wr   = 1'b1;
				load_addr = e.addr;
			end
		endcase
		if (e.op == OP_MIDI)
			cpu_addr = 16'(PORT_MIDI);
		next_cycle();
		clear_strobes();
		cycles = 1;
		case (e.op)
			OP_IOR, OP_MR, OP_LDRD: begin
				while (!read_valid(e.op) && cycles < 6) begin
					next_cycle();
					cycles++;
				end
				assert (read_valid(e.op)) else begin
					$display("No read data came back for address %h", e.addr);
					failure_cnt++;
				end
				if (read_valid(e.op)) begin
					assert (cycles == ((e.op == OP_IOR) ? 1 : 2)) else begin
						$display("Read data for %h came %0d cycles after the strobe",
						         e.addr, cycles);
						failure_cnt++;
					end
					if (e.op == OP_IOR)
						check_val("io_rdata", io_rdata, e.exp);
					else
						check_val("mem_rdata", mem_rdata, e.exp);
				end
				next_cycle();
			end
			OP_MIDI: begin
				// Counted from the edge before the strobe
				while (!int_midi && cycles < MIDI_WAIT + 1) begin
					next_cycle();
					cycles++;
				end
				assert (int_midi) else begin
					$display("int_midi did not rise within %0d cycles of the MIDI write",
					         MIDI_WAIT);
					failure_cnt++;
				end
				check_val("midi_busy", midi_busy, 1'b1);
				st      = e;
				st.op   = OP_IOR;
				st.addr = PORT_STAT;
				apply_entry(st);
				cycles = 0;
				while (int_midi && cycles < CLEAR_WAIT) begin
					next_cycle();
					cycles++;
				end
				assert (!int_midi) else begin
					$display("int_midi did not clear at the end of the byte time");
					failure_cnt++;
				end
				check_val("midi_busy", midi_busy, 1'b0);
				st.exp = 8'hFF;
				apply_entry(st);
			end
			default: next_cycle();
		endcase
		check_val("audio_l", audio_l, e.aud_l);
		check_val("audio_r", audio_r, e.aud_r);
		check_val("border_color", border_color, e.border);
	endtask

	// ==================================================
	// Stimulus table and run
	// ==================================================
	initial begin
		logic [13:0] rom_off [0:5];
		logic [13:0] off [0:3];
		logic [4:0]  pg;
		seed = 32'h9d28e068;
		mismatch_cnt = 0;
		failure_cnt  = 0;
		{ref_lmpr, ref_hmpr, ref_brdr, ref_latch, ref_vl, ref_vr, ref_stb} = '0;
		reset = 1'b1;
		cpu_addr  = '0;
		cpu_wdata = '0;
		load_addr = '0;
		load_data = '0;
		clear_strobes();

		// Register state after reset
		add_entry(OP_IOR, PORT_LMPR, 20'h0, 8'h00);
		add_entry(OP_IOR, PORT_HMPR, 20'h0, 8'h00);
		add_entry(OP_IOR, PORT_STAT, 20'h0, 8'h00);
		add_entry(OP_IOR, PORT_LPTD, 20'h0, 8'h00);
		add_entry(OP_IOR, PORT_LPTS, 20'h0, 8'h00);
		add_entry(OP_IOR, 20'h10, 20'h0, 8'h00);

		// ROM image in page 16 followed by ROM0 and ROM1 overlays
		for (int i = 0; i < 6; i++) begin
			rom_off[i] = 14'($random(seed));
			add_entry(OP_LW, {ROM_PAGE, 1'b0, rom_off[i]}, 20'h0, 8'($random(seed)));
			add_entry(OP_LW, {ROM_PAGE, 1'b1, rom_off[i]}, 20'h0, 8'($random(seed)));
		end
		for (int i = 0; i < 6; i++) begin
			add_entry(OP_MR, {6'h00, rom_off[i]}, 20'h0, 8'h00);
			add_entry(OP_MW, {6'h00, rom_off[i]}, 20'h0, 8'($random(seed)));
			add_entry(OP_MR, {6'h00, rom_off[i]}, 20'h0, 8'h00);
		end
		add_entry(OP_IOW, PORT_LMPR, 20'h0, 8'h40);
		add_entry(OP_IOR, PORT_LMPR, 20'h0, 8'h00);
		for (int i = 0; i < 6; i++)
			add_entry(OP_MR, {6'h03, rom_off[i]}, 20'h0, 8'h00);

		// Paging through all four regions with a wrap from page 31 on the first pass
		for (int i = 0; i < 5; i++) begin
			pg = (i == 0) ? 5'd31 : 5'($random(seed));
			add_entry(OP_IOW, PORT_LMPR, 20'h0, {3'b001, pg});
			add_entry(OP_IOW, PORT_HMPR, 20'h0, 8'($random(seed)));
			add_entry(OP_IOR, PORT_HMPR, 20'h0, 8'h00);
			for (int r = 0; r < 4; r++) begin
				off[r] = 14'($random(seed));
				add_entry(OP_MW, {4'h0, 2'(r), off[r]}, 20'h0, 8'($random(seed)));
				add_entry(OP_MR, {4'h0, 2'(r), off[r]}, 20'h0, 8'h00);
			end
			add_entry(OP_IOW, PORT_LMPR, 20'h0, {3'b001, pg + 5'd1});
			add_entry(OP_MR, {6'h00, off[1]}, 20'h0, 8'h00);
			// Region 0 write protect
			add_entry(OP_IOW, PORT_LMPR, 20'h0, {3'b101, pg + 5'd1});
			add_entry(OP_IOR, PORT_LMPR, 20'h0, 8'h00);
			add_entry(OP_MW, {6'h00, off[1]}, 20'h0, 8'($random(seed)));
			add_entry(OP_MR, {6'h00, off[1]}, 20'h0, 8'h00);
		end

		// Loader writes colliding with CPU reads
		for (int i = 0; i < 4; i++) begin
			off[0] = 14'($random(seed));
			off[1] = 14'($random(seed));
			add_entry(OP_MW, {6'h01, off[0]}, 20'h0, 8'($random(seed)));
			add_entry(OP_LDRD, {6'h01, off[0]}, {1'b0, ref_hmpr[4:0], off[1]}, 8'($random(seed)));
			add_entry(OP_MR, {6'h02, off[1]}, 20'h0, 8'h00);
		end

		// DAC strobe edges alternate while border and EAR change each time
		for (int i = 0; i < 6; i++) begin
			add_entry(OP_IOW, PORT_BRDR, 20'h0, 8'($random(seed)));
			add_entry(OP_IOW, PORT_LPTD, 20'h0, 8'($random(seed)));
			add_entry(OP_IOW, PORT_LPTS, 20'h0, {7'($random(seed)), ~i[0]});
		end
		add_entry(OP_IOW, PORT_LPTD, 20'h0, 8'($random(seed)));
		add_entry(OP_IOW, PORT_LPTS, 20'h0, 8'h00);

		add_entry(OP_MIDI, PORT_MIDI, 20'h0, 8'h00);
		add_entry(OP_MIDI, PORT_MIDI, 20'h0, 8'h00);

		repeat (4) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check_val("io_rvalid", io_rvalid, 1'b0);
		check_val("mem_rvalid", mem_rvalid, 1'b0);
		check_val("int_midi", int_midi, 1'b0);
		check_val("midi_busy", midi_busy, 1'b0);

		foreach (stim_q[i])
			apply_entry(stim_q[i]);

		$display("Checks done: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
		if (mismatch_cnt == 0 && failure_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: hdl/samcoupe_asic.sv
// CPU bus uses one-cycle strobes with at most one CPU strobe every two cycles; no back-pressure
module samcoupe_asic
	import asic_pkg::*;
#(
	parameter int TICK_DIV = 96
)
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic [CPU_ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0]     cpu_wdata,
	input  logic                  io_wr,
	input  logic                  io_rd,
	input  logic                  mem_wr,
	input  logic                  mem_rd,

	input  logic                  load_wr,
	input  logic [RAM_ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0]     load_data,

	output logic [DATA_W-1:0]     io_rdata,
	output logic                  io_rvalid,
	output logic [DATA_W-1:0]     mem_rdata,
	output logic                  mem_rvalid,

	output logic [3:0]            border_color,
	output logic [AUDIO_W-1:0]    audio_l,
	output logic [AUDIO_W-1:0]    audio_r,
	output logic                  int_midi,
	output logic                  midi_busy
);

	logic [DATA_W-1:0]     lmpr;
	logic [DATA_W-1:0]     hmpr;
	logic                  ear;
	logic                  midi_wr;
	logic                  lptd_wr;
	logic                  lpts_wr;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  wr_allow;
	logic                  ram_en;
	logic                  ram_we;
	logic [RAM_ADDR_W-1:0] ram_a;
	logic [DATA_W-1:0]     ram_d;
	logic [DATA_W-1:0]     ram_q;

	asic_ports ports_i (
		.clk_sys, .reset, .cpu_addr, .cpu_wdata, .io_wr, .io_rd, .int_midi,
		.lmpr, .hmpr, .ear, .border_color, .midi_wr, .lptd_wr, .lpts_wr,
		.io_rdata, .io_rvalid
	);

	page_mapper mapper_i (.cpu_addr, .lmpr, .hmpr, .ram_addr, .wr_allow);

	mem_arbiter arbiter_i (
		.clk_sys, .reset, .mem_rd, .mem_wr, .ram_addr, .wr_allow, .cpu_wdata,
		.load_wr, .load_addr, .load_data,
		.ram_en, .ram_we, .ram_a, .ram_d, .ram_q, .mem_rdata, .mem_rvalid
	);

	sys_ram #(.DEPTH_W(RAM_ADDR_W)) ram_i (
		.clk_sys, .ram_en, .ram_we, .ram_a, .ram_d, .ram_q
	);

	midi_tx #(.TICK_DIV(TICK_DIV)) midi_i (
		.clk_sys, .reset, .midi_wr, .int_midi, .midi_busy
	);

	dac_audio dac_i (
		.clk_sys, .reset, .lptd_wr, .lpts_wr, .cpu_wdata, .ear, .audio_l, .audio_r
	);

endmodule

// File: hdl/dac_audio.sv
// Two-register parallel DAC as used by printer-port samplers; output is unsigned audio
module dac_audio
	import asic_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               lptd_wr,
	input  logic               lpts_wr,
	input  logic [DATA_W-1:0]  cpu_wdata,
	input  logic               ear,
	output logic [AUDIO_W-1:0] audio_l,
	output logic [AUDIO_W-1:0] audio_r
);

	logic [DATA_W-1:0] data_latch;
	logic [DATA_W-1:0] vox_l;
	logic [DATA_W-1:0] vox_r;
	logic              old_stb;

	// Voice byte doubled to full scale, EAR adds a fixed step at bit 17
	function automatic logic [AUDIO_W-1:0] mix_voice(input logic [DATA_W-1:0] vox,
	                                                 input logic ear_bit);
		logic [18:0] sum;
		sum = {1'b0, vox, vox, 2'b00} + {1'b0, ear_bit, 17'd0};
		return sum[18:3];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			data_latch <= '0;
			vox_l      <= '0;
			vox_r      <= '0;
			old_stb    <= 1'b0;
		end else begin
			if (lptd_wr)
				data_latch <= cpu_wdata;

			if (lpts_wr) begin
				// Rising strobe feeds left, falling strobe feeds right
				if (!old_stb && cpu_wdata[0])
					vox_l <= data_latch;
				if (old_stb && !cpu_wdata[0])
					vox_r <= data_latch;
				old_stb <= cpu_wdata[0];
			end
		end
	end

	assign audio_l = mix_voice(vox_l, ear);
	assign audio_r = mix_voice(vox_r, ear);

endmodule

// File: hdl/midi_tx.sv
// Timing model only, no serial line; TICK_DIV must give a 1 MHz tick from clk_sys
module midi_tx
	import asic_pkg::*;
#(
	parameter int TICK_DIV = 96
)
(
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_wr,
	output logic int_midi,
	output logic midi_busy
);

	localparam int DIV_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam int TIME_W = $clog2(MIDI_BYTE_TICKS);

	logic [DIV_W-1:0]  div_cnt;
	logic              tick;
	logic [TIME_W-1:0] tx_time;
	logic              pending;

	assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt   <= '0;
			tx_time   <= '0;
			pending   <= 1'b0;
			int_midi  <= 1'b0;
			midi_busy <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;

			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					if (tx_time == TIME_W'(MIDI_INT_TICK))
						int_midi <= 1'b1;
				end else begin
					// Byte time over, start the next one if queued
					int_midi  <= 1'b0;
					midi_busy <= pending;
					if (pending) begin
						tx_time <= TIME_W'(MIDI_BYTE_TICKS - 1);
						pending <= 1'b0;
					end
				end
			end

			// A new write wins over the clear above
			if (midi_wr)
				pending <= 1'b1;
		end
	end

endmodule

// File: hdl/sys_ram.sv
// Single-port byte RAM with registered read; contents power up undefined and are never cleared
module sys_ram
	import asic_pkg::*;
#(
	parameter int DEPTH_W = RAM_ADDR_W
)
(
	input  logic               clk_sys,
	input  logic               ram_en,
	input  logic               ram_we,
	input  logic [DEPTH_W-1:0] ram_a,
	input  logic [DATA_W-1:0]  ram_d,
	output logic [DATA_W-1:0]  ram_q
);

	logic [DATA_W-1:0] mem [0:(1 << DEPTH_W)-1];

	// Read data holds until the next read
	always_ff @(posedge clk_sys) begin
		if (ram_en) begin
			if (ram_we)
				mem[ram_a] <= ram_d;
			else
				ram_q <= mem[ram_a];
		end
	end

endmodule

// File: hdl/mem_arbiter.sv
// CPU requests always win; the one-entry loader buffer assumes no two loader strobes in a row
module mem_arbiter
	import asic_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  mem_rd,
	input  logic                  mem_wr,
	input  logic [RAM_ADDR_W-1:0] ram_addr,
	input  logic                  wr_allow,
	input  logic [DATA_W-1:0]     cpu_wdata,

	input  logic                  load_wr,
	input  logic [RAM_ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0]     load_data,

	output logic                  ram_en,
	output logic                  ram_we,
	output logic [RAM_ADDR_W-1:0] ram_a,
	output logic [DATA_W-1:0]     ram_d,
	input  logic [DATA_W-1:0]     ram_q,

	output logic [DATA_W-1:0]     mem_rdata,
	output logic                  mem_rvalid
);

	logic                  cpu_req;
	logic                  issue_buf;
	logic                  issue_load;
	logic                  buf_load;
	logic                  lbuf_valid;
	logic [RAM_ADDR_W-1:0] lbuf_addr;
	logic [DATA_W-1:0]     lbuf_data;
	logic                  rd_p1;
	logic                  rd_p2;

	// Protected writes never take the RAM slot
	assign cpu_req    = mem_rd || (mem_wr && wr_allow);
	assign issue_buf  = !cpu_req && lbuf_valid;
	assign issue_load = !cpu_req && !lbuf_valid && load_wr;
	// Loader write parks whenever the slot is taken
	assign buf_load   = load_wr && !issue_load;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_en     <= 1'b0;
			ram_we     <= 1'b0;
			lbuf_valid <= 1'b0;
			rd_p1      <= 1'b0;
			rd_p2      <= 1'b0;
		end else begin
			ram_en     <= cpu_req || issue_buf || issue_load;
			ram_we     <= cpu_req ? mem_wr : (issue_buf || issue_load);
			lbuf_valid <= buf_load || (lbuf_valid && !issue_buf);
			// Read tag, one stage for the request and one for the RAM
			rd_p1      <= mem_rd;
			rd_p2      <= rd_p1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_req) begin
			ram_a <= ram_addr;
			ram_d <= cpu_wdata;
		end else if (issue_buf) begin
			ram_a <= lbuf_addr;
			ram_d <= lbuf_data;
		end else begin
			ram_a <= load_addr;
			ram_d <= load_data;
		end

		if (buf_load) begin
			lbuf_addr <= load_addr;
			lbuf_data <= load_data;
		end
	end

	assign mem_rdata  = ram_q;
	assign mem_rvalid = rd_p2;

endmodule

// File: hdl/page_mapper.sv
// Purely combinational; cpu_addr must be stable for the whole access, and only 32 RAM pages exist
module page_mapper
	import asic_pkg::*;
(
	input  logic [CPU_ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0]     lmpr,
	input  logic [DATA_W-1:0]     hmpr,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  wr_allow
);

	localparam int OFFS_W = 14;

	logic [1:0]        region;
	logic [OFFS_W-1:0] offset;
	logic              rom0_sel;
	logic              rom1_sel;
	logic              rom_sel;
	logic              ram_wp;
	page_t             page;

	assign region = cpu_addr[CPU_ADDR_W-1 -: 2];
	assign offset = cpu_addr[OFFS_W-1:0];

	// ROM0 is paged in while LMPR bit 5 is low, ROM1 while LMPR bit 6 is high
	assign rom0_sel = !lmpr[5] && (region == 2'd0);
	assign rom1_sel = lmpr[6] && (region == 2'd3);
	assign rom_sel  = rom0_sel || rom1_sel;

	// Region 0 write protect
	assign ram_wp = lmpr[7] && (region == 2'd0);

	// Upper half of each pair is the next page up, wrapping at 31
	always_comb begin
		case (region)
			2'd0:    page = lmpr[4:0];
			2'd1:    page = lmpr[4:0] + 5'd1;
			2'd2:    page = hmpr[4:0];
			default: page = hmpr[4:0] + 5'd1;
		endcase
	end

	always_comb begin
		if (rom_sel)
			ram_addr = {ROM_PAGE, cpu_addr[CPU_ADDR_W-1], offset};
		else
			ram_addr = {1'b0, page, offset};
	end

	assign wr_allow = !rom_sel && !ram_wp;

endmodule

// File: hdl/asic_ports.sv
// Port numbers use only cpu_addr[7:0]; strobes are single-cycle and the read value lags io_rd by one cycle
module asic_ports
	import asic_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic [CPU_ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0]     cpu_wdata,
	input  logic                  io_wr,
	input  logic                  io_rd,

	input  logic                  int_midi,

	output logic [DATA_W-1:0]     lmpr,
	output logic [DATA_W-1:0]     hmpr,
	output logic                  ear,
	output logic [3:0]            border_color,

	output logic                  midi_wr,
	output logic                  lptd_wr,
	output logic                  lpts_wr,

	output logic [DATA_W-1:0]     io_rdata,
	output logic                  io_rvalid
);

	logic [7:0]        port;
	logic [DATA_W-1:0] brdr;
	logic [DATA_W-1:0] rd_value;

	assign port = cpu_addr[7:0];

	// ==================================================
	// Write decode
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr <= '0;
			hmpr <= '0;
			brdr <= '0;
		end else if (io_wr) begin
			if (port == PORT_LMPR)
				lmpr <= cpu_wdata;
			if (port == PORT_HMPR)
				hmpr <= cpu_wdata;
			if (port == PORT_BRDR)
				brdr <= cpu_wdata;
		end
	end

	// Strobes to MIDI timer and DAC, same cycle as io_wr
	assign midi_wr = io_wr && (port == PORT_MIDI);
	assign lptd_wr = io_wr && (port == PORT_LPTD);
	assign lpts_wr = io_wr && (port == PORT_LPTS);

	// Bit 3 is MIC, not used on this machine
	assign border_color = {brdr[5], brdr[2:0]};
	assign ear          = brdr[4];

	// ==================================================
	// Read mux
	// ==================================================
	always_comb begin
		case (port)
			PORT_LMPR: rd_value = lmpr;
			PORT_HMPR: rd_value = hmpr;
			// Status is active low, only the MIDI bit is live
			PORT_STAT: rd_value = {3'b111, ~int_midi, 4'b1111};
			// Parallel ports have no printer behind them
			PORT_LPTD,
			PORT_LPTS: rd_value = '0;
			default:   rd_value = '1;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_rvalid <= 1'b0;
			io_rdata  <= '0;
		end else begin
			io_rvalid <= io_rd;
			if (io_rd)
				io_rdata <= rd_value;
		end
	end

endmodule

// File: hdl/asic_pkg.sv
// Shared widths and constants; the RAM is 1 MB, so page numbers stop at 31 and the ROM sits in page 16
package asic_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W     = 8;
	localparam int RAM_ADDR_W = 20;

	// 16 KB page number within the 1 MB RAM
	typedef logic [4:0] page_t;

	// ROM0 and ROM1 share this page, split by CPU address bit 15
	localparam page_t ROM_PAGE = 5'd16;

	// ==================================================
	// I/O port numbers (low byte of the CPU address)
	// ==================================================
	localparam logic [7:0] PORT_LPTD = 8'hE8;
	localparam logic [7:0] PORT_LPTS = 8'hE9;
	localparam logic [7:0] PORT_STAT = 8'hF9;
	localparam logic [7:0] PORT_LMPR = 8'hFA;
	localparam logic [7:0] PORT_HMPR = 8'hFB;
	localparam logic [7:0] PORT_MIDI = 8'hFD;
	localparam logic [7:0] PORT_BRDR = 8'hFE;

	// ==================================================
	// MIDI and audio
	// ==================================================
	// One byte time in 1 MHz ticks (10 bits at 31.25 kbaud)
	localparam int MIDI_BYTE_TICKS = 320;
	// Interrupt raised this many ticks before the byte ends
	localparam int MIDI_INT_TICK   = 15;

	localparam int AUDIO_W = 16;

endpackage
